// File: tb.f
rtl/i2s_pkg.sv
rtl/slot_cmd_pkg.sv
rtl/i2s_frame_if.sv
rtl/slot_cmd_decoder.sv
rtl/i2s_frame_fsm.sv
rtl/i2s_bit_counter.sv
rtl/i2s_sample_shifter.sv
rtl/adc_slot_rx.sv
sim/adc_slot_rx_assert.sv
sim/tb_adc_slot_rx.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the ADC slot receiver testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_adc_slot_rx -f tb.f -o sim_tb

./obj_dir/sim_tb 2>&1 | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: sim/tb_adc_slot_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_adc_slot_rx;
    import i2s_pkg::*;
    import slot_cmd_pkg::*;

    localparam int SAMPLE_BITS    = SAMPLE_BITS_DEFAULT;
    localparam int COUNT_BITS     = COUNT_BITS_DEFAULT;
    localparam int SLOTS_PER_HALF = 32;
    localparam int WAIT_LIMIT     = 2000;

    logic                       adc_pbck;
    logic                       reset;
    logic                       adc_plrck;
    logic                       adc_sdata;
    logic                       ctl_valid;
    logic [CMD_BYTE_BITS-1:0]   ctl_data;
    logic                       aud_wr_valid;
    logic [AUDIO_WORD_BITS-1:0] aud_wr_data;
    logic                       aud_wr_right;
    logic [CMD_BYTE_BITS-1:0]   acon;
    logic                       recording;

    // Reference model state
    logic                       exp_recording;
    logic [CMD_BYTE_BITS-1:0]   exp_acon;
    logic [AUDIO_WORD_BITS-1:0] exp_word_q[$];
    logic                       exp_right_q[$];
    int                         word_count;
    logic                       next_right;

    adc_slot_rx #(
        .SAMPLE_BITS (SAMPLE_BITS),
        .COUNT_BITS  (COUNT_BITS)
    ) dut_i (
        .adc_pbck     (adc_pbck),
        .reset        (reset),
        .adc_plrck    (adc_plrck),
        .adc_sdata    (adc_sdata),
        .ctl_valid    (ctl_valid),
        .ctl_data     (ctl_data),
        .aud_wr_valid (aud_wr_valid),
        .aud_wr_data  (aud_wr_data),
        .aud_wr_right (aud_wr_right),
        .acon         (acon),
        .recording    (recording)
    );

    always #5 adc_pbck = ~adc_pbck;

    // Sample lands in the low bits, everything above stays zero
    function automatic logic [AUDIO_WORD_BITS-1:0] ref_word(input logic [SAMPLE_BITS-1:0] sample);
        logic [AUDIO_WORD_BITS-1:0] word;
        word = '0;
        for (int i = 0; i < SAMPLE_BITS; i++) begin
            word[i] = sample[i];
        end
        return word;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            fail_run($sformatf("ERR %0t: %s got %h expected %h", $time, what, actual, expected));
        end
    endtask

    // One half-frame of 32 slots, MSB in slot 1, filler bits elsewhere
    task automatic send_half(input logic right, input logic keep);
        logic [SAMPLE_BITS-1:0] sample;
        sample = SAMPLE_BITS'($urandom);
        if (keep) begin
            exp_word_q.push_back(ref_word(sample));
            exp_right_q.push_back(right);
        end
        for (int slot = 0; slot < SLOTS_PER_HALF; slot++) begin
            @(posedge adc_pbck);
            adc_plrck <= right;
            if (slot >= 1 && slot <= SAMPLE_BITS) begin
                adc_sdata <= sample[SAMPLE_BITS - slot];
            end else begin
                adc_sdata <= 1'($urandom);
            end
        end
    endtask

    task automatic send_frames(input int count);
        logic latch;
        for (int f = 0; f < count; f++) begin
            // Recording state at the left start decides the whole frame
            latch = exp_recording;
            send_half(1'b0, latch);
            send_half(1'b1, latch);
        end
    endtask

    task automatic send_byte(input logic [CMD_BYTE_BITS-1:0] value);
        @(posedge adc_pbck);
        ctl_valid <= 1'b1;
        ctl_data  <= value;
        @(posedge adc_pbck);
        ctl_valid <= 1'b0;
        ctl_data  <= '0;
    endtask

    task automatic start_recording();
        send_byte(OP_START_RECORDING);
        exp_recording = 1'b1;
    endtask

    task automatic stop_recording();
        send_byte(OP_STOP_RECORDING);
        exp_recording = 1'b0;
    endtask

    task automatic set_acon(input logic [CMD_BYTE_BITS-1:0] value);
        send_byte(OP_SET_ACON);
        send_byte(value);
        exp_acon = value;
    endtask

    task automatic wait_drained(input int limit);
        int waited;
        waited = 0;
        while (exp_word_q.size() != 0) begin
            if (waited >= limit) begin
                fail_run("Timeout while waiting for the expected audio words");
            end else begin
                @(negedge adc_pbck);
                waited++;
            end
        end
    endtask

    // Outputs are stable at the falling edge
    always @(negedge adc_pbck) begin
        if (!reset && aud_wr_valid) begin
            if (exp_word_q.size() == 0) begin
                fail_run($sformatf("Audio word %h appeared at %0t with none expected",
                                   aud_wr_data, $time));
            end else begin
                check_value(32'(aud_wr_right), 32'(next_right), "left/right order");
                check_value(aud_wr_data, exp_word_q.pop_front(), "audio word");
                check_value(32'(aud_wr_right), 32'(exp_right_q.pop_front()), "channel flag");
                next_right = ~next_right;
                word_count++;
            end
        end
    end

    initial begin
        logic [CMD_BYTE_BITS-1:0] acon_value;
        void'($urandom(32'h3881493a));
        adc_pbck      = 1'b0;
        reset         = 1'b1;
        adc_plrck     = 1'b1;
        adc_sdata     = 1'b0;
        ctl_valid     = 1'b0;
        ctl_data      = '0;
        exp_recording = 1'b0;
        exp_acon      = ACON_DEFAULT;
        word_count    = 0;
        next_right    = 1'b0;
        repeat (3) @(posedge adc_pbck);
        reset <= 1'b0;

        // Reset values and silence while not recording
        @(negedge adc_pbck);
        check_value(32'(acon), 32'(ACON_DEFAULT), "acon after reset");
        check_value(32'(recording), 32'd0, "recording after reset");
        send_frames(3);
        check_value(word_count, 0, "words while idle");

        start_recording();
        @(negedge adc_pbck);
        check_value(32'(recording), 32'd1, "recording after start");
        send_frames(4);

        // Stop lands in the left half of the fifth frame
        fork
            send_frames(1);
            begin
                repeat (16) @(posedge adc_pbck);
                stop_recording();
            end
        join
        send_frames(3);
        wait_drained(WAIT_LIMIT);
        check_value(word_count, 10, "words through stop");

        acon_value = CMD_BYTE_BITS'($urandom);
        set_acon(acon_value);
        @(negedge adc_pbck);
        check_value(32'(acon), 32'(exp_acon), "acon after set");
        send_byte(8'h7e);
        send_byte(8'h00);
        @(negedge adc_pbck);
        check_value(32'(acon), 32'(exp_acon), "acon after unknown opcode");
        check_value(32'(recording), 32'(exp_recording), "recording after unknown opcode");

        // Random mix of recording on and off
        for (int i = 0; i < 8; i++) begin
            if ($urandom_range(0, 1) == 1) begin
                start_recording();
            end else begin
                stop_recording();
            end
            send_frames(int'($urandom_range(1, 4)));
        end
        start_recording();
        send_frames(2);

        // A last falling LRCK edge releases the final right word
        @(posedge adc_pbck);
        adc_plrck <= 1'b0;
        adc_sdata <= 1'b0;
        wait_drained(WAIT_LIMIT);
        repeat (2 * SLOTS_PER_HALF) @(negedge adc_pbck);
        check_value(word_count % 2, 0, "word count parity");

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/adc_slot_rx_assert.sv
`timescale 1ns/1ps
`default_nettype none

module adc_slot_rx_assert (
    input wire                               adc_pbck,
    input wire                               reset,
    input wire                               aud_wr_valid,
    input wire [i2s_pkg::AUDIO_WORD_BITS-1:0] aud_wr_data
);
    import i2s_pkg::*;

    localparam int PAD_BITS = AUDIO_WORD_BITS - SAMPLE_BITS_DEFAULT;

    // Strobe is a single-cycle pulse
    valid_single_cycle: assert property (
        @(posedge adc_pbck) disable iff (reset)
        aud_wr_valid |=> !aud_wr_valid
    ) else $error("aud_wr_valid stayed high for two cycles");

    // Quiet in reset once the first reset edge has been taken
    valid_low_in_reset: assert property (
        @(posedge adc_pbck)
        (reset && $past(reset)) |-> !aud_wr_valid
    ) else $error("aud_wr_valid high during reset");

    // Zero extension of the sample
    upper_bits_zero: assert property (
        @(posedge adc_pbck) disable iff (reset)
        aud_wr_valid |-> (aud_wr_data[AUDIO_WORD_BITS-1 -: PAD_BITS] == '0)
    ) else $error("upper bits of aud_wr_data not zero");

endmodule

bind adc_slot_rx adc_slot_rx_assert assert_i (
    .adc_pbck     (adc_pbck),
    .reset        (reset),
    .aud_wr_valid (aud_wr_valid),
    .aud_wr_data  (aud_wr_data)
);

`default_nettype wire

// File: rtl/adc_slot_rx.sv
`timescale 1ns/1ps
`default_nettype none

module adc_slot_rx #(
    parameter int SAMPLE_BITS = i2s_pkg::SAMPLE_BITS_DEFAULT,
    parameter int COUNT_BITS  = i2s_pkg::COUNT_BITS_DEFAULT
) (
    input  wire                                    adc_pbck,
    input  wire                                    reset,
    input  wire                                    adc_plrck,
    input  wire                                    adc_sdata,
    input  wire                                    ctl_valid,
    input  wire  [slot_cmd_pkg::CMD_BYTE_BITS-1:0] ctl_data,
    output logic                                   aud_wr_valid,
    output logic [i2s_pkg::AUDIO_WORD_BITS-1:0]    aud_wr_data,
    output logic                                   aud_wr_right,
    output logic [slot_cmd_pkg::CMD_BYTE_BITS-1:0] acon,
    output logic                                   recording
);

    // Frame timing shared by the FSM, counter and shifter
    i2s_frame_if #(.COUNT_BITS(COUNT_BITS)) frame_i ();

    // Recording enable goes to the port and to the FSM latch
    slot_cmd_decoder cmd_i (
        .adc_pbck         (adc_pbck),
        .reset            (reset),
        .ctl_valid        (ctl_valid),
        .ctl_data         (ctl_data),
        .recording_enable (recording),
        .acon             (acon)
    );

    i2s_frame_fsm fsm_i (
        .adc_pbck         (adc_pbck),
        .reset            (reset),
        .adc_plrck        (adc_plrck),
        .recording_enable (recording),
        .frame            (frame_i.fsm),
        .aud_wr_valid     (aud_wr_valid),
        .aud_wr_right     (aud_wr_right)
    );

    i2s_bit_counter #(
        .SAMPLE_BITS (SAMPLE_BITS),
        .COUNT_BITS  (COUNT_BITS)
    ) counter_i (
        .adc_pbck (adc_pbck),
        .reset    (reset),
        .frame    (frame_i.counter)
    );

    i2s_sample_shifter #(
        .SAMPLE_BITS (SAMPLE_BITS)
    ) shifter_i (
        .adc_pbck    (adc_pbck),
        .reset       (reset),
        .adc_sdata   (adc_sdata),
        .frame       (frame_i.shifter),
        .aud_wr_data (aud_wr_data)
    );

endmodule

`default_nettype wire

// File: rtl/i2s_sample_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_sample_shifter #(
    parameter int SAMPLE_BITS = i2s_pkg::SAMPLE_BITS_DEFAULT
) (
    input  wire                               adc_pbck,
    input  wire                               reset,
    input  wire                               adc_sdata,
    i2s_frame_if.shifter                      frame,
    output logic [i2s_pkg::AUDIO_WORD_BITS-1:0] aud_wr_data
);
    import i2s_pkg::*;

    localparam int PAD_BITS = AUDIO_WORD_BITS - SAMPLE_BITS;

    logic [SAMPLE_BITS-1:0] shift_q;

    // Sample register, MSB arrives first
    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            shift_q <= '0;
        end else if (frame.frame_edge) begin
            shift_q <= '0;
        end else if (frame.capture) begin
            shift_q <= {shift_q[SAMPLE_BITS-2:0], adc_sdata};
        end
    end

    // Output word, valid one cycle after the transition with the strobe
    always_ff @(posedge adc_pbck) begin
        if (frame.frame_edge) begin
            aud_wr_data <= {{PAD_BITS{1'b0}}, shift_q};
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2s_bit_counter.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_bit_counter #(
    parameter int SAMPLE_BITS = i2s_pkg::SAMPLE_BITS_DEFAULT,
    parameter int COUNT_BITS  = i2s_pkg::COUNT_BITS_DEFAULT
) (
    input  wire          adc_pbck,
    input  wire          reset,
    i2s_frame_if.counter frame
);

    localparam logic [COUNT_BITS-1:0] COUNT_MAX = {COUNT_BITS{1'b1}};

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            // Start saturated so nothing is captured before the first edge
            frame.bit_count <= COUNT_MAX;
        end else if (frame.frame_edge) begin
            frame.bit_count <= '0;
        end else if (frame.bit_count != COUNT_MAX) begin
            frame.bit_count <= frame.bit_count + 1'b1;
        end
    end

    // Bits at edges E+1 .. E+SAMPLE_BITS belong to the sample
    assign frame.capture = (frame.bit_count < COUNT_BITS'(SAMPLE_BITS)) && !frame.frame_edge;

endmodule

`default_nettype wire

// File: rtl/i2s_frame_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module i2s_frame_fsm (
    input  wire         adc_pbck,
    input  wire         reset,
    input  wire         adc_plrck,
    input  wire         recording_enable,
    i2s_frame_if.fsm    frame,
    output logic        aud_wr_valid,
    output logic        aud_wr_right
);
    import i2s_pkg::*;

    logic lrck_q;
    // Recording enable as seen at the last left boundary
    logic rec_latch;
    logic lrck_fall;

    assign frame.frame_edge = (adc_plrck != lrck_q);
    assign lrck_fall        = frame.frame_edge && !adc_plrck;

    // Word strobe comes straight from the emit pulse
    assign aud_wr_valid = frame.emit;

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            lrck_q            <= 1'b0;
            rec_latch         <= 1'b0;
            frame.frame_state <= FRAME_IDLE;
            frame.emit        <= 1'b0;
            aud_wr_right      <= 1'b0;
        end else begin
            lrck_q     <= adc_plrck;
            frame.emit <= 1'b0;

            if (frame.frame_edge) begin
                // Old latch value decides, so a stop mid-frame still
                // lets the right word of that frame out
                frame.emit   <= rec_latch && (frame.frame_state != FRAME_IDLE);
                aud_wr_right <= (frame.frame_state == FRAME_RIGHT);

                if (lrck_fall) begin
                    frame.frame_state <= FRAME_LEFT;
                    rec_latch         <= recording_enable;
                end else begin
                    case (frame.frame_state)
                        FRAME_LEFT:  frame.frame_state <= FRAME_RIGHT;
                        default:     frame.frame_state <= frame.frame_state;
                    endcase
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/slot_cmd_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module slot_cmd_decoder (
    input  wire                                  adc_pbck,
    input  wire                                  reset,
    input  wire                                  ctl_valid,
    input  wire  [slot_cmd_pkg::CMD_BYTE_BITS-1:0] ctl_data,
    output logic                                 recording_enable,
    output logic [slot_cmd_pkg::CMD_BYTE_BITS-1:0] acon
);
    import slot_cmd_pkg::*;

    slot_opcode_t op_q;
    // 0 while waiting for an opcode, 1 while waiting for a data byte
    logic         byte_idx;

    always_ff @(posedge adc_pbck) begin
        if (reset) begin
            op_q             <= OP_STOP_RECORDING;
            byte_idx         <= 1'b0;
            recording_enable <= 1'b0;
            acon             <= ACON_DEFAULT;
        end else if (ctl_valid) begin
            if (!byte_idx) begin
                op_q <= slot_opcode_t'(ctl_data);
                case (slot_opcode_t'(ctl_data))
                    OP_START_RECORDING: begin
                        recording_enable <= 1'b1;
                    end
                    OP_STOP_RECORDING: begin
                        recording_enable <= 1'b0;
                    end
                    OP_SET_ACON: begin
                        // Data byte follows
                        byte_idx <= 1'b1;
                    end
                    default: begin
                        // Unknown opcode, dropped as a single byte
                        byte_idx <= 1'b0;
                    end
                endcase
            end else begin
                case (op_q)
                    OP_SET_ACON: begin
                        acon <= ctl_data;
                    end
                    default: begin
                        acon <= acon;
                    end
                endcase
                byte_idx <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/i2s_frame_if.sv
`timescale 1ns/1ps
`default_nettype none

interface i2s_frame_if #(
    parameter int COUNT_BITS = i2s_pkg::COUNT_BITS_DEFAULT
);
    import i2s_pkg::*;

    // LRCK changed this cycle (combinational)
    logic                  frame_edge;
    frame_state_t          frame_state;
    // One-cycle pulse after a finished half-frame that is to be reported
    logic                  emit;
    // Sample bit window
    logic                  capture;
    logic [COUNT_BITS-1:0] bit_count;

    modport fsm (
        output frame_edge,
        output frame_state,
        output emit
    );

    modport counter (
        input  frame_edge,
        output capture,
        output bit_count
    );

    modport shifter (
        input frame_edge,
        input capture
    );

endinterface

`default_nettype wire

// File: rtl/slot_cmd_pkg.sv
`default_nettype none

package slot_cmd_pkg;

    // Control stream is byte wide
    localparam int CMD_BYTE_BITS = 8;

    // Opcodes understood by the ADC slot
    // Start and stop are single bytes, SET_ACON carries one data byte
    typedef enum logic [7:0] {
        OP_START_RECORDING = 8'h12,
        OP_STOP_RECORDING  = 8'h13,
        OP_SET_ACON        = 8'h14
    } slot_opcode_t;

    // Power-up configuration for the ADC card
    localparam logic [CMD_BYTE_BITS-1:0] ACON_DEFAULT = 8'h51;

endpackage

`default_nettype wire

// File: rtl/i2s_pkg.sv
`default_nettype none

package i2s_pkg;

    // Sample bits taken per channel after each LRCK change
    localparam int SAMPLE_BITS_DEFAULT = 24;

    // Bit counter width, enough for a 32-bit half-frame plus saturation
    localparam int COUNT_BITS_DEFAULT = 6;

    // Audio word handed to the host side, sample is zero-extended into it
    localparam int AUDIO_WORD_BITS = 32;

    // Half-frame tracking
    // IDLE is only left on a falling LRCK edge, so a partial
    // first half-frame is never reported
    typedef enum logic [1:0] {
        FRAME_IDLE  = 2'd0,
        FRAME_LEFT  = 2'd1,
        FRAME_RIGHT = 2'd2
    } frame_state_t;

endpackage

`default_nettype wire
